// ==== cpu16.f ====
src/uarchPkg.sv
src/isaPkg.sv
src/alu.sv
src/datapath.sv
src/sequencer.sv
src/mainMemory.sv
src/cpuTop.sv
testbench/cpuAssert.sv
testbench/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f cpu16.f -o cpuSim \
    || { echo "build failed"; exit 1; }
simOut=$(./obj_dir/cpuSim)
echo "$simOut"
echo "$simOut" | grep -qx "TEST PASS" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== testbench/cpuTb.sv ====
/* testbench for the microcoded CPU: program assembly and loading, ALU
   reference model, directed tests and a watchdog */
`timescale 1ns/10ps

module cpuTb import uarchPkg::*, isaPkg::*; ();

    localparam int progWords = 128;
    localparam int numTests = 5;
    localparam int cyclesPerTest = 400;   // reset, program load and the longest run
    localparam logic [5:0] ctlAnd = 6'b000000;
    localparam logic [5:0] ctlAdd = 6'(1 << aluF);
    localparam logic [5:0] ctlSub = 6'((1 << aluNx) | (1 << aluF) | (1 << aluNo));
    localparam logic [5:0] ctlNeg = 6'((1 << aluZy) | (1 << aluNy) | (1 << aluF) | (1 << aluNo));

    logic clk = 1'b0;
    logic rstN;
    logic progWe;
    logic [memAddrWidth-1:0] progAddr;
    logic [dataWidth-1:0] progData;
    logic [dataWidth-1:0] outData;
    logic outValid;
    logic halted;
    logic [dataWidth-1:0] pc;

    logic [dataWidth-1:0] prog [progWords];
    logic [dataWidth-1:0] outs [$];
    int asmPtr;
    int expCycles;   // only meaningful for straight-line programs

    cpuTop dut (
        .clk(clk), .rstN(rstN), .progWe(progWe), .progAddr(progAddr),
        .progData(progData), .outData(outData), .outValid(outValid),
        .halted(halted), .pc(pc)
    );

    always #4 clk = ~clk;

    function automatic logic [dataWidth-1:0] aluModel(input logic [5:0] ctl,
            input logic [dataWidth-1:0] x, input logic [dataWidth-1:0] y);
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [dataWidth-1:0] r;
        a = x;
        b = y;
        if (ctl[aluZx]) a = '0;
        if (ctl[aluNx]) a = ~a;
        if (ctl[aluZy]) b = '0;
        if (ctl[aluNy]) b = ~b;
        r = ctl[aluF] ? a + b : a & b;
        if (ctl[aluNo]) r = ~r;
        return r;
    endfunction

    task automatic checkValue(input string name, input logic [dataWidth-1:0] expected,
                              input logic [dataWidth-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic clearProgram();
        for (int a = 0; a < progWords; a++) begin
            prog[a] = {~8'(a), 8'(a)};   // undefined opcodes, unique per word
        end
        asmPtr = 0;
        expCycles = 0;
        outs.delete();
    endtask

    task automatic emit(input opcode code, input logic [7:0] imm);
        prog[asmPtr] = {code, imm};
        asmPtr++;
        // two fetch cycles and one execute step, one more for a memory access
        // a halt counts three as well since halted rises in its t2
        expCycles += (code inside {opLdx, opLdy, opStx}) ? 4 : 3;
    endtask

    // reset, program load, then run until halted while collecting out values
    task automatic runAndCheck(input string name, input logic [dataWidth-1:0] expected [$],
                               output int cycles);
        @(posedge clk);
        rstN <= 1'b0;
        repeat (3) @(posedge clk);
        for (int a = 0; a < progWords; a++) begin
            progWe <= 1'b1;
            progAddr <= memAddrWidth'(a);
            progData <= prog[a];
            @(posedge clk);
        end
        progWe <= 1'b0;
        rstN <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (outValid) begin
                outs.push_back(outData);
            end
        end while (!halted);
        checkValue({name, " output count"}, 16'(expected.size()), 16'(outs.size()));
        foreach (expected[i]) begin
            checkValue($sformatf("%s output %0d", name, i), expected[i], outs[i]);
        end
    endtask

    task automatic immediateLoads();
        logic [dataWidth-1:0] expected [$];
        int cycles;
        clearProgram();
        emit(opLix, 8'h5A);
        emit(opOut, 8'h00);
        emit(opLixh, 8'h3C);
        emit(opOut, 8'h00);
        emit(opLix, 8'h00);
        emit(opOut, 8'h00);
        emit(opLixh, 8'hFF);
        emit(opOut, 8'h00);
        emit(opHlt, 8'h00);
        expected = {16'h005A, 16'hFF3C, 16'h0000, 16'hFFFF};
        runAndCheck("immediateLoads", expected, cycles);
    endtask

    task automatic aluFunctions();
        logic [5:0] codes [5];
        logic [dataWidth-1:0] x;
        logic [dataWidth-1:0] y;
        logic [dataWidth-1:0] expected [$];
        int cycles;
        codes = '{ctlAdd, ctlAnd, ctlSub, ctlNeg, aluPassX};
        clearProgram();
        for (int r = 0; r < 2; r++) begin
            x = 16'($urandom);
            y = 16'($urandom);
            prog['h60 + 2 * r] = x;
            prog['h61 + 2 * r] = y;
            emit(opLdy, 8'('h61 + 2 * r));
            foreach (codes[i]) begin
                emit(opLdx, 8'('h60 + 2 * r));   // the previous result replaced X
                emit(opAlu, {2'b00, codes[i]});
                emit(opOut, 8'h00);
                expected.push_back(aluModel(codes[i], x, y));
            end
        end
        emit(opHlt, 8'h00);
        runAndCheck("aluFunctions", expected, cycles);
    endtask

    task automatic storeReload();
        logic [dataWidth-1:0] v;
        logic [dataWidth-1:0] expected [$];
        int cycles;
        clearProgram();
        v = 16'($urandom);
        prog['h60] = v;
        emit(opLdx, 8'h60);
        emit(opAlu, {2'b00, ctlNeg});
        emit(opStx, 8'h68);
        emit(opLix, 8'h00);
        emit(opOut, 8'h00);
        emit(opLdx, 8'h68);
        emit(opOut, 8'h00);
        emit(opHlt, 8'h00);
        expected = {16'h0000, aluModel(ctlNeg, v, 16'h0000)};
        runAndCheck("storeReload", expected, cycles);
    endtask

    task automatic conditionalJumps();
        opcode jumps [3];
        logic [dataWidth-1:0] expected [$];
        logic taken;
        int base;
        int cycles;
        jumps = '{opJz, opJlt, opJgt};
        clearProgram();
        for (int v = 0; v < 3; v++) begin   // X is zero, then negative, then positive
            foreach (jumps[j]) begin
                base = asmPtr;
                case (v)
                    0: emit(opLix, 8'h00);
                    1: emit(opLixh, 8'h80);
                    default: emit(opLix, 8'h45);
                endcase
                emit(opAlu, {2'b00, aluPassX});
                emit(jumps[j], 8'(base + 5));
                emit(opLix, 8'(16 * v + 4 * j));       // marker of the fall-through path
                emit(opJmp, 8'(base + 6));
                emit(opLix, 8'(16 * v + 4 * j + 1));
                emit(opOut, 8'h00);
                case (jumps[j])
                    opJz: taken = (v == 0);
                    opJlt: taken = (v == 1);
                    default: taken = (v == 2);
                endcase
                expected.push_back(16'(16 * v + 4 * j + (taken ? 1 : 0)));
            end
        end
        emit(opHlt, 8'h00);
        runAndCheck("conditionalJumps", expected, cycles);
    endtask

    task automatic haltTiming();
        logic [dataWidth-1:0] expected [$];
        int cycles;
        int haltAddr;
        clearProgram();
        emit(opLix, 8'h11);
        emit(opLiy, 8'h22);
        emit(opAlu, {2'b00, ctlAdd});
        emit(opOut, 8'h00);
        emit(opStx, 8'h70);
        emit(opLdy, 8'h70);
        emit(opLdx, 8'h70);
        emit(opJmp, 8'(asmPtr + 1));
        emit(opNop, 8'h00);
        haltAddr = asmPtr;
        emit(opHlt, 8'h00);
        expected = {16'h0033};
        runAndCheck("haltTiming", expected, cycles);
        checkValue("haltTiming cycles", 16'(expCycles), 16'(cycles));
        repeat (5) begin
            @(negedge clk);
            checkValue("haltTiming pc", 16'(haltAddr + 1), pc);
            checkValue("haltTiming halted", 16'h0001, 16'(halted));
        end
    endtask

    initial begin
        repeat (numTests * cyclesPerTest) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles",
                 numTests * cyclesPerTest);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rstN = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        void'($urandom(21715));
        immediateLoads();
        aluFunctions();
        storeReload();
        conditionalJumps();
        haltTiming();
        checkValue("bound assertions", 16'h0000, 16'(dut.seqInst.seqChecks.sourceFails
            + dut.seqInst.seqChecks.outValidFails + dut.seqInst.seqChecks.haltFails));
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== testbench/cpuAssert.sv ====
/* concurrent checks on the sequencer strobes, bound into the sequencer */
`timescale 1ns/10ps

module cpuAssert import uarchPkg::*; (
    input logic  clk,
    input logic  rstN,
    input tState tStep,
    input logic  pcOut,
    input logic  immLowOut,
    input logic  immHighOut,
    input logic  memOut,
    input logic  aluOut,
    input logic  outValid,
    input logic  halted
);

    int sourceFails = 0;
    int outValidFails = 0;
    int haltFails = 0;

    // the bus is a plain OR of its sources, so two at once would corrupt it
    assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({pcOut, immLowOut, immHighOut, memOut, aluOut}))
        else begin
            sourceFails++;
            $error("more than one bus source strobe is active");
        end

    assert property (@(posedge clk) disable iff (!rstN) outValid |-> aluOut)
        else begin
            outValidFails++;   // X reaches the bus only through the ALU
            $error("outValid is high without aluOut");
        end

    assert property (@(posedge clk) disable iff (!rstN) halted |=> (halted && tStep == t2))
        else begin
            haltFails++;
            $error("halted dropped or the step left t2 before reset");
        end

endmodule

bind sequencer cpuAssert seqChecks (
    .clk(clk), .rstN(rstN), .tStep(tStep), .pcOut(pcOut), .immLowOut(immLowOut),
    .immHighOut(immHighOut), .memOut(memOut), .aluOut(aluOut),
    .outValid(outValid), .halted(halted)
);

// ==== src/cpuTop.sv ====
/* CPU top level joining the sequencer, the datapath and main memory */
`timescale 1ns/10ps

module cpuTop import uarchPkg::*, isaPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    progWe,
    input  logic [memAddrWidth-1:0] progAddr,
    input  logic [dataWidth-1:0]    progData,
    output logic [dataWidth-1:0]    outData,
    output logic                    outValid,
    output logic                    halted,
    output logic [dataWidth-1:0]    pc
);

    logic pcOut, immLowOut, immHighOut, memOut, aluOut;
    logic xLoad, yLoad, arLoad, irLoad, pcLoad, pcInc, aluPass, memWrite;
    logic zero, lessThan;
    opcode op;
    logic [dataWidth-1:0] bus;
    logic [dataWidth-1:0] memRdData;
    logic [memAddrWidth-1:0] memAddr;

    assign outData = bus;   // X is on the bus while outValid is high

    sequencer seqInst (
        .clk(clk), .rstN(rstN), .op(op), .zero(zero), .lessThan(lessThan),
        .pcOut(pcOut), .immLowOut(immLowOut), .immHighOut(immHighOut),
        .memOut(memOut), .aluOut(aluOut), .xLoad(xLoad), .yLoad(yLoad),
        .arLoad(arLoad), .irLoad(irLoad), .pcLoad(pcLoad), .pcInc(pcInc),
        .aluPass(aluPass), .memWrite(memWrite), .outValid(outValid), .halted(halted)
    );

    datapath dpInst (
        .clk(clk), .rstN(rstN), .pcOut(pcOut), .immLowOut(immLowOut),
        .immHighOut(immHighOut), .memOut(memOut), .aluOut(aluOut),
        .xLoad(xLoad), .yLoad(yLoad), .arLoad(arLoad), .irLoad(irLoad),
        .pcLoad(pcLoad), .pcInc(pcInc), .aluPass(aluPass), .memRdData(memRdData),
        .bus(bus), .memAddr(memAddr), .op(op), .zero(zero), .lessThan(lessThan),
        .pc(pc)
    );

    mainMemory memInst (
        .clk(clk), .addr(memAddr), .wrData(bus), .we(memWrite),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .rdData(memRdData)
    );

endmodule

// ==== src/mainMemory.sv ====
/* 256-word unified memory with a combinational read port, a clocked
   write port and a program load port */
`timescale 1ns/10ps

module mainMemory import uarchPkg::*; (
    input  logic                    clk,
    input  logic [memAddrWidth-1:0] addr,
    input  logic [dataWidth-1:0]    wrData,
    input  logic                    we,
    input  logic                    progWe,
    input  logic [memAddrWidth-1:0] progAddr,
    input  logic [dataWidth-1:0]    progData,
    output logic [dataWidth-1:0]    rdData
);

    logic [dataWidth-1:0] mem [2**memAddrWidth];

    // program loading happens only while the CPU is held in reset
    always_ff @(posedge clk) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end else if (we) begin
            mem[addr] <= wrData;
        end
    end

    assign rdData = mem[addr];   // read within the same cycle

endmodule

// ==== src/sequencer.sv ====
/* microcode step counter and decoder that turn the opcode and the
   current step into bus source and register load strobes */
`timescale 1ns/10ps

module sequencer import uarchPkg::*, isaPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  opcode op,
    input  logic  zero,
    input  logic  lessThan,
    output logic  pcOut,
    output logic  immLowOut,
    output logic  immHighOut,
    output logic  memOut,
    output logic  aluOut,
    output logic  xLoad,
    output logic  yLoad,
    output logic  arLoad,
    output logic  irLoad,
    output logic  pcLoad,
    output logic  pcInc,
    output logic  aluPass,
    output logic  memWrite,
    output logic  outValid,
    output logic  halted
);

    tState tStep;
    logic inT2;
    logic inT3;
    logic memOp;
    logic jumpTaken;
    logic stepReset;

    assign inT2 = (tStep == t2);
    assign inT3 = (tStep == t3);
    assign memOp = op inside {opLdx, opLdy, opStx};   // these need a fourth step

    // fetch is the same for every instruction
    assign pcOut = (tStep == t0);
    assign irLoad = (tStep == t1);
    assign pcInc = irLoad;

    assign arLoad = pcOut | (inT2 & memOp);
    assign memOut = irLoad | (inT3 & (op inside {opLdx, opLdy}));
    assign immLowOut = inT2 & (op inside {opLix, opLiy, opLdx, opLdy, opStx,
                                          opJmp, opJz, opJlt, opJgt});
    assign immHighOut = inT2 & (op == opLixh);

    // out and stx route X through the ALU unchanged
    assign aluPass = (inT2 & (op == opOut)) | (inT3 & (op == opStx));
    assign aluOut = aluPass | (inT2 & (op == opAlu));

    assign xLoad = (inT2 & (op inside {opLix, opLixh, opAlu})) | (inT3 & (op == opLdx));
    assign yLoad = (inT2 & (op == opLiy)) | (inT3 & (op == opLdy));
    assign memWrite = inT3 & (op == opStx);
    assign outValid = inT2 & (op == opOut);
    assign halted = inT2 & (op == opHlt);

    always_comb begin
        case (op)
            opJmp: jumpTaken = 1'b1;
            opJz: jumpTaken = zero;
            opJlt: jumpTaken = lessThan;
            opJgt: jumpTaken = !zero && !lessThan;
            default: jumpTaken = 1'b0;
        endcase
    end

    assign pcLoad = inT2 & jumpTaken;

    // unknown opcodes finish in t2 like a nop
    assign stepReset = inT3 | (inT2 & !memOp & !halted);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            tStep <= t0;
        end else if (stepReset) begin
            tStep <= t0;
        end else if (!halted) begin
            tStep <= tState'(tStep + 2'd1);
        end
    end

endmodule

// ==== src/datapath.sv ====
/* register file of X, Y, PC, IR and AR, the single bus multiplexer
   and the ALU with its flags */
`timescale 1ns/10ps

module datapath import uarchPkg::*, isaPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    pcOut,
    input  logic                    immLowOut,
    input  logic                    immHighOut,
    input  logic                    memOut,
    input  logic                    aluOut,
    input  logic                    xLoad,
    input  logic                    yLoad,
    input  logic                    arLoad,
    input  logic                    irLoad,
    input  logic                    pcLoad,
    input  logic                    pcInc,
    input  logic                    aluPass,
    input  logic [dataWidth-1:0]    memRdData,
    output logic [dataWidth-1:0]    bus,
    output logic [memAddrWidth-1:0] memAddr,
    output opcode                   op,
    output logic                    zero,
    output logic                    lessThan,
    output logic [dataWidth-1:0]    pc
);

    logic [dataWidth-1:0] xReg;
    logic [dataWidth-1:0] yReg;
    logic [dataWidth-1:0] irReg;
    logic [memAddrWidth-1:0] arReg;
    logic [dataWidth-1:0] immLow;
    logic [dataWidth-1:0] immHigh;
    logic [dataWidth-1:0] aluResult;
    logic [aluCtlWidth-1:0] aluCtl;

    assign immLow = dataWidth'(irReg[immMsb:immLsb]);
    assign immHigh = {{(dataWidth - memAddrWidth){1'b1}}, irReg[immMsb:immLsb]};

    // the sequencer enables one source at a time, so a plain OR is enough
    assign bus = ({dataWidth{pcOut}} & pc)
               | ({dataWidth{immLowOut}} & immLow)
               | ({dataWidth{immHighOut}} & immHigh)
               | ({dataWidth{memOut}} & memRdData)
               | ({dataWidth{aluOut}} & aluResult);

    assign aluCtl = aluPass ? aluPassX : irReg[aluCtlWidth-1:0];
    assign op = opcode'(irReg[opMsb:opLsb]);
    assign memAddr = arReg;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            xReg <= '0;
            yReg <= '0;
            irReg <= '0;
            arReg <= '0;
            pc <= '0;
        end else begin
            if (xLoad) xReg <= bus;
            if (yLoad) yReg <= bus;
            if (irLoad) irReg <= bus;
            if (arLoad) arReg <= bus[memAddrWidth-1:0];
            if (pcLoad) begin
                pc <= bus;                 // jump target from the immediate
            end else if (pcInc) begin
                pc <= pc + 1'b1;
            end
        end
    end

    alu aluInst (
        .clk      (clk),
        .rstN     (rstN),
        .x        (xReg),
        .y        (yReg),
        .ctl      (aluCtl),
        .capture  (aluOut),
        .result   (aluResult),
        .zero     (zero),
        .lessThan (lessThan)
    );

endmodule

// ==== src/alu.sv ====
/* six-control-bit ALU with the zero and less-than flag register */
`timescale 1ns/10ps

module alu import uarchPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [dataWidth-1:0]   x,
    input  logic [dataWidth-1:0]   y,
    input  logic [aluCtlWidth-1:0] ctl,
    input  logic                   capture,
    output logic [dataWidth-1:0]   result,
    output logic                   zero,
    output logic                   lessThan
);

    logic [dataWidth-1:0] xZeroed;
    logic [dataWidth-1:0] xFinal;
    logic [dataWidth-1:0] yZeroed;
    logic [dataWidth-1:0] yFinal;
    logic [dataWidth-1:0] funcOut;

    assign xZeroed = ctl[aluZx] ? '0 : x;
    assign xFinal = ctl[aluNx] ? ~xZeroed : xZeroed;
    assign yZeroed = ctl[aluZy] ? '0 : y;
    assign yFinal = ctl[aluNy] ? ~yZeroed : yZeroed;

    assign funcOut = ctl[aluF] ? (xFinal + yFinal) : (xFinal & yFinal);
    assign result = ctl[aluNo] ? ~funcOut : funcOut;

    // flags follow whatever the ALU last drove onto the bus
    always_ff @(posedge clk) begin
        if (!rstN) begin
            zero <= 1'b0;
            lessThan <= 1'b0;
        end else if (capture) begin
            zero <= (result == '0);
            lessThan <= result[dataWidth-1];   // sign bit
        end
    end

endmodule

// ==== src/isaPkg.sv ====
/* instruction set definitions: opcode encoding, instruction field bounds
   and the ALU code that passes X unchanged */
package isaPkg;

    typedef enum logic [7:0] {
        opNop = 8'h00,
        opLix = 8'h01,    // X = zero-extended immediate
        opLixh = 8'h02,   // X = 0xFF00 | immediate
        opLiy = 8'h03,
        opLdx = 8'h04,
        opLdy = 8'h05,
        opStx = 8'h06,
        opAlu = 8'h07,    // low six bits select the function
        opOut = 8'h08,
        opJmp = 8'h09,
        opJz = 8'h0A,
        opJlt = 8'h0B,
        opJgt = 8'h0C,
        opHlt = 8'h0D
    } opcode;

    localparam int opMsb = 15;
    localparam int opLsb = 8;
    localparam int immMsb = 7;
    localparam int immLsb = 0;

    // X + 0 with Y zeroed and the adder selected
    localparam logic [5:0] aluPassX = 6'b001010;

endpackage

// ==== src/uarchPkg.sv ====
/* microarchitecture definitions: data and address widths, microcode step
   encoding and the bit positions of the ALU control field */
package uarchPkg;

    localparam int dataWidth = 16;
    localparam int memAddrWidth = 8;   // matches the immediate field width

    // microcode step of the current instruction
    typedef enum logic [1:0] {
        t0 = 2'd0,
        t1 = 2'd1,
        t2 = 2'd2,
        t3 = 2'd3
    } tState;

    localparam int aluCtlWidth = 6;

    // each bit of the ALU control field
    localparam int aluZx = 5;   // force X to zero
    localparam int aluNx = 4;   // invert X
    localparam int aluZy = 3;   // force Y to zero
    localparam int aluNy = 2;   // invert Y
    localparam int aluF = 1;    // add when set, bitwise and when clear
    localparam int aluNo = 0;   // invert the result

endpackage
